/* Bender.yml */
package:
  name: rename_core

sources:
  - rename_pkg.sv
  - inst_decode.sv
  - map_table.sv
  - reorder_buffer.sv
  - rename_stage.sv
  - rename_core.sv
  - target: simulation
    files:
      - tb_clock_gen.sv
      - tb_rename_core.sv

/* inst_decode.sv */
`default_nettype none

module inst_decode
    import rename_pkg::*;
(
    input  logic clk,
    input  logic reset,
    input  logic inst_valid,
    input  inst_word_t inst,
    output logic dec_valid,
    output logic [reg_addr_len-1:0] dec_src1,
    output logic [reg_addr_len-1:0] dec_src2,
    output logic [reg_addr_len-1:0] dec_dest
);

    logic [reg_addr_len-1:0] src1_d;
    logic [reg_addr_len-1:0] src2_d;
    logic [reg_addr_len-1:0] dest_d;

    // Both formats keep rs1 and rd on the same bits, only the second source differs
    always_comb begin
        src1_d = inst.r_fmt.rs1;
        dest_d = inst.r_fmt.rd;
        if (inst.r_fmt.opcode == op_reg) begin
            src2_d = inst.r_fmt.rs2;
        end else begin
            // The immediate takes the place of the second source
            src2_d = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= inst_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (inst_valid) begin
            dec_src1 <= src1_d;
            dec_src2 <= src2_d;
            dec_dest <= dest_d;
        end
    end

endmodule

`default_nettype wire

/* map_table.sv */
`default_nettype none

module map_table
    import rename_pkg::*;
#(
    parameter int rob_tag_len = 3
) (
    input  logic clk,
    input  logic reset,
    input  logic [reg_addr_len-1:0] src1_reg,
    input  logic [reg_addr_len-1:0] src2_reg,
    input  logic [reg_addr_len-1:0] assign_reg,
    input  logic [reg_addr_len-1:0] retire_reg,
    input  logic assign_flag,
    input  logic return_flag,
    input  logic ready_flag,
    input  logic [rob_tag_len-1:0] assign_tag,
    input  logic [rob_tag_len-1:0] retire_tag,
    input  logic [rob_tag_len-1:0] cdb_tag,
    output logic [1:0] src1_stat,
    output logic [1:0] src2_stat,
    output logic [rob_tag_len-1:0] src1_tag,
    output logic [rob_tag_len-1:0] src2_tag
);

    localparam logic [rob_tag_len-1:0] no_tag = '1;

    logic [rob_tag_len-1:0] tag_q [reg_num];
    logic ready_q [reg_num];
    logic [rob_tag_len-1:0] tag_d [reg_num];
    logic ready_d [reg_num];

    // ############################################################
    // Update rules
    // ############################################################

    // Later rules override earlier ones, so assign goes last and wins
    always_comb begin
        tag_d = tag_q;
        ready_d = ready_q;

        if (ready_flag) begin
            for (int i = 1; i < reg_num; i++) begin
                if (tag_q[i] == cdb_tag) begin
                    ready_d[i] = 1'b1;
                end
            end
        end

        // Only drop the mapping if nobody has renamed the register since
        if (return_flag && tag_q[retire_reg] == retire_tag) begin
            tag_d[retire_reg] = no_tag;
            ready_d[retire_reg] = 1'b0;
        end

        if (assign_flag && assign_reg != '0) begin
            tag_d[assign_reg] = assign_tag;
            ready_d[assign_reg] = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < reg_num; i++) begin
                tag_q[i] <= no_tag;
                ready_q[i] <= 1'b0;
            end
        end else begin
            tag_q <= tag_d;
            ready_q <= ready_d;
        end
    end

    // ############################################################
    // Source lookup
    // ############################################################

    function automatic logic [1:0] lookup_stat(
        input logic [reg_addr_len-1:0] r,
        input logic [rob_tag_len-1:0] t,
        input logic rdy
    );
        if (r == '0 || t == no_tag) begin
            return stat_regfile;
        end
        return rdy ? stat_in_rob : stat_waiting;
    endfunction

    function automatic logic [rob_tag_len-1:0] lookup_tag(
        input logic [reg_addr_len-1:0] r,
        input logic [rob_tag_len-1:0] t
    );
        return (r == '0) ? no_tag : t;
    endfunction

    // Lookups see the table as it was before this edge
    assign src1_stat = lookup_stat(src1_reg, tag_q[src1_reg], ready_q[src1_reg]);
    assign src1_tag = lookup_tag(src1_reg, tag_q[src1_reg]);
    assign src2_stat = lookup_stat(src2_reg, tag_q[src2_reg], ready_q[src2_reg]);
    assign src2_tag = lookup_tag(src2_reg, tag_q[src2_reg]);

    // The reorder buffer must never hand out the reserved code
    assign_real_tag: assert property (
        @(posedge clk) disable iff (reset)
        assign_flag |-> assign_tag != no_tag
    );

endmodule

`default_nettype wire

/* rename_core.sv */
`default_nettype none

module rename_core
    import rename_pkg::*;
#(
    parameter int rob_tag_len = 3
) (
    input  logic clk,
    input  logic reset,
    input  logic inst_valid,
    input  inst_word_t inst,
    input  logic cdb_valid,
    input  logic [rob_tag_len-1:0] cdb_tag,
    output logic renamed_valid,
    output logic inst_dropped,
    output logic [reg_addr_len-1:0] out_src1_reg,
    output logic [1:0] out_src1_stat,
    output logic [rob_tag_len-1:0] out_src1_tag,
    output logic [reg_addr_len-1:0] out_src2_reg,
    output logic [1:0] out_src2_stat,
    output logic [rob_tag_len-1:0] out_src2_tag,
    output logic [reg_addr_len-1:0] out_dest,
    output logic [rob_tag_len-1:0] out_dest_tag,
    output logic retire_valid,
    output logic [reg_addr_len-1:0] retire_dest,
    output logic [rob_tag_len-1:0] retire_tag
);

    logic dec_valid;
    logic [reg_addr_len-1:0] dec_src1;
    logic [reg_addr_len-1:0] dec_src2;
    logic [reg_addr_len-1:0] dec_dest;
    logic [1:0] src1_stat;
    logic [1:0] src2_stat;
    logic [rob_tag_len-1:0] src1_tag;
    logic [rob_tag_len-1:0] src2_tag;
    logic alloc;
    logic full;
    logic [rob_tag_len-1:0] alloc_tag;
    logic assign_flag;
    logic [rob_tag_len-1:0] assign_tag;

    inst_decode decode0 (
        .clk        (clk),
        .reset      (reset),
        .inst_valid (inst_valid),
        .inst       (inst),
        .dec_valid  (dec_valid),
        .dec_src1   (dec_src1),
        .dec_src2   (dec_src2),
        .dec_dest   (dec_dest)
    );

    rename_stage #(
        .rob_tag_len (rob_tag_len)
    ) rename0 (
        .clk           (clk),
        .reset         (reset),
        .dec_valid     (dec_valid),
        .dec_src1      (dec_src1),
        .dec_src2      (dec_src2),
        .dec_dest      (dec_dest),
        .src1_stat     (src1_stat),
        .src2_stat     (src2_stat),
        .src1_tag      (src1_tag),
        .src2_tag      (src2_tag),
        .alloc_tag     (alloc_tag),
        .full          (full),
        .alloc         (alloc),
        .assign_flag   (assign_flag),
        .assign_tag    (assign_tag),
        .renamed_valid (renamed_valid),
        .inst_dropped  (inst_dropped),
        .out_src1_reg  (out_src1_reg),
        .out_src1_stat (out_src1_stat),
        .out_src1_tag  (out_src1_tag),
        .out_src2_reg  (out_src2_reg),
        .out_src2_stat (out_src2_stat),
        .out_src2_tag  (out_src2_tag),
        .out_dest      (out_dest),
        .out_dest_tag  (out_dest_tag)
    );

    // Result bus doubles as the ready flag, retirement as the return
    map_table #(
        .rob_tag_len (rob_tag_len)
    ) map0 (
        .clk         (clk),
        .reset       (reset),
        .src1_reg    (dec_src1),
        .src2_reg    (dec_src2),
        .assign_reg  (dec_dest),
        .retire_reg  (retire_dest),
        .assign_flag (assign_flag),
        .return_flag (retire_valid),
        .ready_flag  (cdb_valid),
        .assign_tag  (assign_tag),
        .retire_tag  (retire_tag),
        .cdb_tag     (cdb_tag),
        .src1_stat   (src1_stat),
        .src2_stat   (src2_stat),
        .src1_tag    (src1_tag),
        .src2_tag    (src2_tag)
    );

    reorder_buffer #(
        .rob_tag_len (rob_tag_len)
    ) rob0 (
        .clk          (clk),
        .reset        (reset),
        .alloc        (alloc),
        .alloc_dest   (dec_dest),
        .cdb_valid    (cdb_valid),
        .cdb_tag      (cdb_tag),
        .alloc_tag    (alloc_tag),
        .full         (full),
        .retire_valid (retire_valid),
        .retire_dest  (retire_dest),
        .retire_tag   (retire_tag)
    );

endmodule

`default_nettype wire

/* rename_pkg.sv */
`default_nettype none

package rename_pkg;

    // ############################################################
    // Register file geometry
    // ############################################################

    localparam int reg_addr_len = 5;
    localparam int reg_num = 32;

    // ############################################################
    // Opcodes
    // ############################################################

    // Anything that is not op_reg decodes in the immediate format
    localparam logic [6:0] op_reg = 7'b0110011;
    localparam logic [6:0] op_imm = 7'b0010011;

    // ############################################################
    // Source state codes
    // ############################################################

    localparam logic [1:0] stat_regfile = 2'b00;
    localparam logic [1:0] stat_waiting = 2'b10;
    localparam logic [1:0] stat_in_rob = 2'b11;

    // One 32-bit word, seen either as register or as immediate format
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [reg_addr_len-1:0] rs2;
            logic [reg_addr_len-1:0] rs1;
            logic [2:0] funct3;
            logic [reg_addr_len-1:0] rd;
            logic [6:0] opcode;
        } r_fmt;
        struct packed {
            logic [11:0] imm12;
            logic [reg_addr_len-1:0] rs1;
            logic [2:0] funct3;
            logic [reg_addr_len-1:0] rd;
            logic [6:0] opcode;
        } i_fmt;
    } inst_word_t;

endpackage

`default_nettype wire

/* rename_stage.sv */
`default_nettype none

module rename_stage
    import rename_pkg::*;
#(
    parameter int rob_tag_len = 3
) (
    input  logic clk,
    input  logic reset,
    input  logic dec_valid,
    input  logic [reg_addr_len-1:0] dec_src1,
    input  logic [reg_addr_len-1:0] dec_src2,
    input  logic [reg_addr_len-1:0] dec_dest,
    input  logic [1:0] src1_stat,
    input  logic [1:0] src2_stat,
    input  logic [rob_tag_len-1:0] src1_tag,
    input  logic [rob_tag_len-1:0] src2_tag,
    input  logic [rob_tag_len-1:0] alloc_tag,
    input  logic full,
    output logic alloc,
    output logic assign_flag,
    output logic [rob_tag_len-1:0] assign_tag,
    output logic renamed_valid,
    output logic inst_dropped,
    output logic [reg_addr_len-1:0] out_src1_reg,
    output logic [1:0] out_src1_stat,
    output logic [rob_tag_len-1:0] out_src1_tag,
    output logic [reg_addr_len-1:0] out_src2_reg,
    output logic [1:0] out_src2_stat,
    output logic [rob_tag_len-1:0] out_src2_tag,
    output logic [reg_addr_len-1:0] out_dest,
    output logic [rob_tag_len-1:0] out_dest_tag
);

    // There is no stall path, so a full reorder buffer drops the instruction
    assign alloc = dec_valid && !full;
    assign assign_flag = alloc;
    assign assign_tag = alloc_tag;

    always_ff @(posedge clk) begin
        if (reset) begin
            renamed_valid <= 1'b0;
            inst_dropped <= 1'b0;
        end else begin
            renamed_valid <= alloc;
            inst_dropped <= dec_valid && full;
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            out_src1_reg <= dec_src1;
            out_src1_stat <= src1_stat;
            out_src1_tag <= src1_tag;
            out_src2_reg <= dec_src2;
            out_src2_stat <= src2_stat;
            out_src2_tag <= src2_tag;
            out_dest <= dec_dest;
            out_dest_tag <= alloc_tag;
        end
    end

endmodule

`default_nettype wire

/* reorder_buffer.sv */
`default_nettype none

module reorder_buffer
    import rename_pkg::*;
#(
    parameter int rob_tag_len = 3
) (
    input  logic clk,
    input  logic reset,
    input  logic alloc,
    input  logic [reg_addr_len-1:0] alloc_dest,
    input  logic cdb_valid,
    input  logic [rob_tag_len-1:0] cdb_tag,
    output logic [rob_tag_len-1:0] alloc_tag,
    output logic full,
    output logic retire_valid,
    output logic [reg_addr_len-1:0] retire_dest,
    output logic [rob_tag_len-1:0] retire_tag
);

    // The all-ones code is reserved, so one slot fewer than the tag space
    localparam int depth = (1 << rob_tag_len) - 1;
    localparam logic [rob_tag_len-1:0] last_idx = rob_tag_len'(depth - 1);
    localparam logic [rob_tag_len-1:0] no_tag = '1;

    logic [reg_addr_len-1:0] dest_q [depth];
    logic done_q [depth];
    logic valid_q [depth];
    logic [rob_tag_len-1:0] head;
    logic [rob_tag_len-1:0] tail;
    logic [rob_tag_len-1:0] count;
    logic pop;

    function automatic logic [rob_tag_len-1:0] next_ptr(input logic [rob_tag_len-1:0] p);
        return (p == last_idx) ? '0 : p + 1'b1;
    endfunction

    // Tags are simply the entry index
    assign alloc_tag = tail;
    assign full = (count == rob_tag_len'(depth));
    assign pop = valid_q[head] && done_q[head];

    // ############################################################
    // Control state
    // ############################################################

    always_ff @(posedge clk) begin
        if (reset) begin
            head <= '0;
            tail <= '0;
            count <= '0;
            retire_valid <= 1'b0;
            for (int i = 0; i < depth; i++) begin
                valid_q[i] <= 1'b0;
            end
        end else begin
            retire_valid <= pop;
            if (alloc) begin
                valid_q[tail] <= 1'b1;
                tail <= next_ptr(tail);
            end
            if (pop) begin
                valid_q[head] <= 1'b0;
                head <= next_ptr(head);
            end
            case ({alloc, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // ############################################################
    // Entry payload and completion
    // ############################################################

    always_ff @(posedge clk) begin
        if (alloc) begin
            dest_q[tail] <= alloc_dest;
            done_q[tail] <= 1'b0;
        end
        if (cdb_valid && cdb_tag != no_tag) begin
            done_q[cdb_tag] <= 1'b1;
        end
    end

    // Retire outputs are loaded together with the head pop
    always_ff @(posedge clk) begin
        if (pop) begin
            retire_dest <= dest_q[head];
            retire_tag <= head;
        end
    end

    no_alloc_when_full: assert property (
        @(posedge clk) disable iff (reset)
        alloc |-> !full
    );

    // Results can only come back for instructions still in flight
    cdb_hits_live_entry: assert property (
        @(posedge clk) disable iff (reset)
        cdb_valid |-> (cdb_tag != no_tag) && valid_q[cdb_tag]
    );

endmodule

`default_nettype wire

/* sources.f */
rename_pkg.sv
inst_decode.sv
map_table.sv
reorder_buffer.sv
rename_stage.sv
rename_core.sv
tb_clock_gen.sv
tb_rename_core.sv

/* tb_clock_gen.sv */
`default_nettype none

module tb_clock_gen #(
    parameter int period = 40,
    parameter int reset_cycles = 3
) (
    output logic clk,
    output logic reset
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    // Reset is released on a falling edge, away from the sampling edge
    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

`default_nettype wire

/* tb_rename_core.sv */
`default_nettype none

module tb_rename_core
    import rename_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int rob_tag_len = 3;
    localparam int depth = (1 << rob_tag_len) - 1;
    localparam logic [rob_tag_len-1:0] no_tag = '1;
    localparam int clk_period = 40;
    localparam int seed = 32'h7151b8c4;
    localparam int random_cycles = 400;
    localparam int burst_cycles = 24;
    localparam int drain_cycles = 40;
    localparam int readback_cycles = 120;
    localparam int total_cycles =
        random_cycles + burst_cycles + drain_cycles + readback_cycles + 4;

    logic clk;
    logic reset;
    logic inst_valid;
    inst_word_t inst;
    logic cdb_valid;
    logic [rob_tag_len-1:0] cdb_tag;
    logic renamed_valid;
    logic inst_dropped;
    logic [reg_addr_len-1:0] out_src1_reg, out_src2_reg, out_dest;
    logic [1:0] out_src1_stat, out_src2_stat;
    logic [rob_tag_len-1:0] out_src1_tag, out_src2_tag, out_dest_tag;
    logic retire_valid;
    logic [reg_addr_len-1:0] retire_dest;
    logic [rob_tag_len-1:0] retire_tag;

    // ############################################################
    // Reference model state as it stands after the last rising edge
    // ############################################################

    logic [rob_tag_len-1:0] m_tag [reg_num];
    logic m_ready [reg_num];
    logic m_done [depth];
    logic [reg_addr_len-1:0] rob_dest [$];
    logic [rob_tag_len-1:0] rob_tag [$];
    logic [rob_tag_len-1:0] m_tail;
    logic d_valid;
    logic [reg_addr_len-1:0] d_src1, d_src2, d_dest;
    logic e_renamed, e_dropped, e_retire;
    logic [reg_addr_len-1:0] e_s1_reg, e_s2_reg, e_dest, e_ret_dest;
    logic [1:0] e_s1_stat, e_s2_stat;
    logic [rob_tag_len-1:0] e_s1_tag, e_s2_tag, e_dest_tag, e_ret_tag;

    int errors, test_errors, tests_run, tests_failed;
    int drops_seen, waiting_seen, in_rob_seen;

    tb_clock_gen #(.period(clk_period), .reset_cycles(3)) clock0 (.clk(clk), .reset(reset));

    rename_core #(.rob_tag_len(rob_tag_len)) dut0 (.*);

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
        test_errors++;
    endtask

    task automatic check_drop(input logic exp_drop);
        if (inst_dropped !== exp_drop) report_mismatch("inst_dropped", inst_dropped, exp_drop);
    endtask

    task automatic check_retire(input logic exp_valid, input logic [reg_addr_len-1:0] exp_dest,
                                input logic [rob_tag_len-1:0] exp_tag);
        if (retire_valid !== exp_valid) report_mismatch("retire_valid", retire_valid, exp_valid);
        if (exp_valid) begin
            if (retire_dest !== exp_dest) report_mismatch("retire_dest", retire_dest, exp_dest);
            if (retire_tag !== exp_tag) report_mismatch("retire_tag", retire_tag, exp_tag);
        end
    endtask

    task automatic check_renamed(input logic exp_valid,
                                 input logic [reg_addr_len-1:0] s1_reg, input logic [1:0] s1_stat,
                                 input logic [rob_tag_len-1:0] s1_tag,
                                 input logic [reg_addr_len-1:0] s2_reg, input logic [1:0] s2_stat,
                                 input logic [rob_tag_len-1:0] s2_tag,
                                 input logic [reg_addr_len-1:0] dest,
                                 input logic [rob_tag_len-1:0] dest_tag);
        if (renamed_valid !== exp_valid) report_mismatch("renamed_valid", renamed_valid, exp_valid);
        if (exp_valid) begin
            if (out_src1_reg !== s1_reg) report_mismatch("out_src1_reg", out_src1_reg, s1_reg);
            if (out_src1_stat !== s1_stat) report_mismatch("out_src1_stat", out_src1_stat, s1_stat);
            if (out_src1_tag !== s1_tag) report_mismatch("out_src1_tag", out_src1_tag, s1_tag);
            if (out_src2_reg !== s2_reg) report_mismatch("out_src2_reg", out_src2_reg, s2_reg);
            if (out_src2_stat !== s2_stat) report_mismatch("out_src2_stat", out_src2_stat, s2_stat);
            if (out_src2_tag !== s2_tag) report_mismatch("out_src2_tag", out_src2_tag, s2_tag);
            if (out_dest !== dest) report_mismatch("out_dest", out_dest, dest);
            if (out_dest_tag !== dest_tag) report_mismatch("out_dest_tag", out_dest_tag, dest_tag);
        end
    endtask

    function automatic logic [1:0] model_stat(input logic [reg_addr_len-1:0] r);
        if (r == '0 || m_tag[r] == no_tag) return stat_regfile;
        return m_ready[r] ? stat_in_rob : stat_waiting;
    endfunction

    function automatic logic [rob_tag_len-1:0] model_tag(input logic [reg_addr_len-1:0] r);
        return (r == '0) ? no_tag : m_tag[r];
    endfunction

    task automatic reset_model();
        for (int i = 0; i < reg_num; i++) begin
            m_tag[i] = no_tag;
            m_ready[i] = 1'b0;
        end
        for (int i = 0; i < depth; i++) m_done[i] = 1'b0;
        rob_dest.delete();
        rob_tag.delete();
        m_tail = '0;
        d_valid = 1'b0;
        e_renamed = 1'b0;
        e_dropped = 1'b0;
        e_retire = 1'b0;
    endtask

    // Advance the model across one rising edge with the inputs now driven
    task automatic step_model(input logic iv, input inst_word_t w, input logic cv,
                              input logic [rob_tag_len-1:0] ct);
        logic full, alloc, pop;
        full = (rob_tag.size() == depth);
        alloc = d_valid && !full;
        pop = (rob_tag.size() != 0) && m_done[rob_tag[0]];
        e_renamed = alloc;
        e_dropped = d_valid && full;
        if (alloc) begin
            e_s1_reg = d_src1;
            e_s1_stat = model_stat(d_src1);
            e_s1_tag = model_tag(d_src1);
            e_s2_reg = d_src2;
            e_s2_stat = model_stat(d_src2);
            e_s2_tag = model_tag(d_src2);
            e_dest = d_dest;
            e_dest_tag = m_tail;
        end
        // Map table applies ready, then return, then assign
        for (int i = 1; i < reg_num; i++) begin
            if (cv && m_tag[i] == ct) m_ready[i] = 1'b1;
        end
        if (e_retire && m_tag[e_ret_dest] == e_ret_tag) begin
            m_tag[e_ret_dest] = no_tag;
            m_ready[e_ret_dest] = 1'b0;
        end
        if (alloc && d_dest != '0) begin
            m_tag[d_dest] = m_tail;
            m_ready[d_dest] = 1'b0;
        end
        if (pop) begin
            e_ret_dest = rob_dest.pop_front();
            e_ret_tag = rob_tag.pop_front();
        end
        e_retire = pop;
        if (alloc) begin
            rob_dest.push_back(d_dest);
            rob_tag.push_back(m_tail);
            m_done[m_tail] = 1'b0;
            m_tail = (m_tail == rob_tag_len'(depth - 1)) ? '0 : m_tail + 1'b1;
        end
        if (cv) m_done[ct] = 1'b1;
        d_valid = iv;
        if (iv) begin
            // rs1 and rd share their bits across both formats
            d_src1 = w.r_fmt.rs1;
            d_src2 = (w.r_fmt.opcode == op_reg) ? w.r_fmt.rs2 : '0;
            d_dest = w.r_fmt.rd;
        end
    endtask

    // ############################################################
    // Stimulus
    // ############################################################

    function automatic logic [reg_addr_len-1:0] pick_reg();
        // Mostly a few low registers, so sources often meet live producers
        if ($urandom_range(0, 3) == 0) return reg_addr_len'($urandom_range(0, reg_num - 1));
        return reg_addr_len'($urandom_range(0, 6));
    endfunction

    function automatic inst_word_t random_inst();
        inst_word_t w;
        w = $urandom;
        if ($urandom_range(0, 1) == 1) begin
            w.r_fmt.opcode = op_reg;
            w.r_fmt.rs2 = pick_reg();
        end else if (w.i_fmt.opcode == op_reg) begin
            w.i_fmt.opcode = op_imm;
        end
        // Both views keep rs1 and rd on the same bits
        w.i_fmt.rs1 = pick_reg();
        w.i_fmt.rd = pick_reg();
        return w;
    endfunction

    task automatic run_phase(input int cycles, input int inst_pct, input int cdb_pct);
        inst_word_t w;
        logic iv, cv;
        logic [rob_tag_len-1:0] ct;
        logic [rob_tag_len-1:0] pending [$];
        repeat (cycles) begin
            iv = ($urandom_range(1, 100) <= inst_pct);
            w = random_inst();
            pending.delete();
            foreach (rob_tag[i]) begin
                if (!m_done[rob_tag[i]]) pending.push_back(rob_tag[i]);
            end
            cv = (pending.size() != 0) && ($urandom_range(1, 100) <= cdb_pct);
            ct = cv ? pending[$urandom_range(0, pending.size() - 1)] : '0;
            inst_valid = iv;
            inst = w;
            cdb_valid = cv;
            cdb_tag = ct;
            step_model(iv, w, cv, ct);
            @(negedge clk);
            check_drop(e_dropped);
            check_renamed(e_renamed, e_s1_reg, e_s1_stat, e_s1_tag, e_s2_reg, e_s2_stat,
                          e_s2_tag, e_dest, e_dest_tag);
            check_retire(e_retire, e_ret_dest, e_ret_tag);
            if (inst_dropped === 1'b1) drops_seen++;
            if (renamed_valid === 1'b1) begin
                if (out_src1_stat === stat_waiting || out_src2_stat === stat_waiting) waiting_seen++;
                if (out_src1_stat === stat_in_rob || out_src2_stat === stat_in_rob) in_rob_seen++;
            end
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (test_errors == 0) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, test_errors);
            tests_failed++;
        end
        errors += test_errors;
        test_errors = 0;
    endtask

    // ############################################################
    // Test sequence and watchdog
    // ############################################################

    initial begin
        inst_valid = 1'b0;
        inst = '0;
        cdb_valid = 1'b0;
        cdb_tag = '0;
        errors = 0;
        test_errors = 0;
        tests_run = 0;
        tests_failed = 0;
        drops_seen = 0;
        waiting_seen = 0;
        in_rob_seen = 0;
        reset_model();
        void'($urandom(seed));
        @(negedge reset);

        if (renamed_valid !== 1'b0) report_mismatch("renamed_valid", renamed_valid, 0);
        if (inst_dropped !== 1'b0) report_mismatch("inst_dropped", inst_dropped, 0);
        if (retire_valid !== 1'b0) report_mismatch("retire_valid", retire_valid, 0);
        if (dut0.dec_valid !== 1'b0) report_mismatch("dec_valid", dut0.dec_valid, 0);
        finish_test("reset_state");

        run_phase(random_cycles, 60, 45);
        if (waiting_seen == 0) begin
            $display("No renamed source was ever seen waiting on a producer tag");
            test_errors++;
        end
        if (in_rob_seen == 0) begin
            $display("No renamed source was ever seen ready in the reorder buffer");
            test_errors++;
        end
        finish_test("random_traffic");

        drops_seen = 0;
        run_phase(burst_cycles, 100, 0);
        if (drops_seen == 0) begin
            $display("A burst without result traffic never dropped an instruction");
            test_errors++;
        end
        finish_test("full_burst");

        run_phase(drain_cycles, 0, 100);
        finish_test("drain");

        run_phase(readback_cycles, 70, 60);
        finish_test("readback");

        $display("tests: %0d run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    initial begin
        #(4 * total_cycles * clk_period);
        $display("Watchdog expired: the run did not finish within %0d cycles", 4 * total_cycles);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire
